//--- hdl/udp_echo_pkg.sv
package udp_echo_pkg;

    // Field widths
    localparam int IP_W   = 32;
    localparam int PORT_W = 16;
    localparam int BYTE_W = 8;

    // Echo service configuration
    localparam logic [PORT_W-1:0] ECHO_PORT = 16'd1234;
    localparam logic [IP_W-1:0]   LOCAL_IP  = {8'd192, 8'd168, 8'd2, 8'd128};
    localparam logic [BYTE_W-1:0] REPLY_TTL = 8'd64;

    localparam int PAYLOAD_FIFO_DEPTH = 16;

    // Per-datagram decision of the port filter
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ECHO = 2'd1,
        DROP = 2'd2
    } filter_state_t;

endpackage

//--- hdl/udp_port_filter.sv
`timescale 1ns/1ns

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              s_hdr_valid,
    input  logic [PORT_W-1:0] s_dst_port,
    output logic              s_hdr_ready,
    input  logic              s_payload_valid,
    input  logic              s_payload_last,
    output logic              s_payload_ready,
    input  logic              hdr_busy,
    output logic              reply_load,
    output logic              fifo_in_valid,
    input  logic              fifo_in_ready
);

    filter_state_t state;

    logic port_match;
    logic hdr_accept;
    logic payload_xfer;

    // Port is only looked at while waiting for a header
    assign port_match = (state == IDLE) && (s_dst_port == ECHO_PORT);

    // A matching header has to wait for a free reply slot
    assign s_hdr_ready = (state == IDLE) && (!port_match || !hdr_busy);
    assign hdr_accept  = s_hdr_valid && s_hdr_ready;
    assign reply_load  = hdr_accept && port_match;

    always_comb begin
        case (state)
            ECHO: begin
                s_payload_ready = fifo_in_ready;
                fifo_in_valid   = s_payload_valid;
            end
            DROP: begin
                // Sink everything until last
                s_payload_ready = 1'b1;
                fifo_in_valid   = 1'b0;
            end
            default: begin
                s_payload_ready = 1'b0;
                fifo_in_valid   = 1'b0;
            end
        endcase
    end

    assign payload_xfer = s_payload_valid && s_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_accept) begin
                        state <= port_match ? ECHO : DROP;
                    end
                end
                ECHO, DROP: begin
                    if (payload_xfer && s_payload_last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/udp_reply_header.sv
`timescale 1ns/1ns

module udp_reply_header
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              reply_load,
    input  logic [IP_W-1:0]   s_src_ip,
    input  logic [PORT_W-1:0] s_src_port,
    input  logic [PORT_W-1:0] s_dst_port,
    input  logic [PORT_W-1:0] s_udp_length,
    output logic              m_hdr_valid,
    input  logic              m_hdr_ready,
    output logic [IP_W-1:0]   m_src_ip,
    output logic [IP_W-1:0]   m_dst_ip,
    output logic [PORT_W-1:0] m_src_port,
    output logic [PORT_W-1:0] m_dst_port,
    output logic [PORT_W-1:0] m_udp_length,
    output logic [BYTE_W-1:0] m_ttl
);

    // Fixed fields of every reply
    assign m_src_ip = LOCAL_IP;
    assign m_ttl    = REPLY_TTL;

    // Ports swap, sender becomes destination
    always_ff @(posedge clk) begin
        if (reply_load) begin
            m_src_port   <= s_dst_port;
            m_dst_port   <= s_src_port;
            m_dst_ip     <= s_src_ip;
            m_udp_length <= s_udp_length;
        end
    end

    // Load only arrives while the slot is empty
    always_ff @(posedge clk) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
        end else if (reply_load) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

endmodule

//--- hdl/payload_fifo.sv
`timescale 1ns/1ns

module payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int DEPTH = PAYLOAD_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [BYTE_W-1:0] in_data,
    input  logic              in_last,
    input  logic              in_user,
    input  logic              in_valid,
    output logic              in_ready,
    output logic [BYTE_W-1:0] out_data,
    output logic              out_last,
    output logic              out_user,
    output logic              out_valid,
    input  logic              out_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    // Entry is {user, last, data}
    logic [BYTE_W+1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              wr_en;
    logic              rd_en;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    assign {out_user, out_last, out_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {in_user, in_last, in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves count unchanged
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/udp_echo_top.sv
`timescale 1ns/1ns

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Parsed request header
    input  logic              s_hdr_valid,
    output logic              s_hdr_ready,
    input  logic [IP_W-1:0]   s_src_ip,
    input  logic [PORT_W-1:0] s_src_port,
    input  logic [PORT_W-1:0] s_dst_port,
    input  logic [PORT_W-1:0] s_udp_length,
    // Request payload
    input  logic [BYTE_W-1:0] s_payload_data,
    input  logic              s_payload_valid,
    output logic              s_payload_ready,
    input  logic              s_payload_last,
    input  logic              s_payload_user,
    // Reply header
    output logic              m_hdr_valid,
    input  logic              m_hdr_ready,
    output logic [IP_W-1:0]   m_src_ip,
    output logic [IP_W-1:0]   m_dst_ip,
    output logic [PORT_W-1:0] m_src_port,
    output logic [PORT_W-1:0] m_dst_port,
    output logic [PORT_W-1:0] m_udp_length,
    output logic [BYTE_W-1:0] m_ttl,
    // Reply payload
    output logic [BYTE_W-1:0] m_payload_data,
    output logic              m_payload_valid,
    input  logic              m_payload_ready,
    output logic              m_payload_last,
    output logic              m_payload_user
);

    logic reply_load;
    logic fifo_in_valid;
    logic fifo_in_ready;

    udp_port_filter i_filter (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_dst_port      (s_dst_port),
        .s_hdr_ready     (s_hdr_ready),
        .s_payload_valid (s_payload_valid),
        .s_payload_last  (s_payload_last),
        .s_payload_ready (s_payload_ready),
        .hdr_busy        (m_hdr_valid),
        .reply_load      (reply_load),
        .fifo_in_valid   (fifo_in_valid),
        .fifo_in_ready   (fifo_in_ready)
    );

    udp_reply_header i_reply_header (
        .clk          (clk),
        .rst          (rst),
        .reply_load   (reply_load),
        .s_src_ip     (s_src_ip),
        .s_src_port   (s_src_port),
        .s_dst_port   (s_dst_port),
        .s_udp_length (s_udp_length),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_src_ip     (m_src_ip),
        .m_dst_ip     (m_dst_ip),
        .m_src_port   (m_src_port),
        .m_dst_port   (m_dst_port),
        .m_udp_length (m_udp_length),
        .m_ttl        (m_ttl)
    );

    payload_fifo #(
        .DEPTH (PAYLOAD_FIFO_DEPTH)
    ) i_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (s_payload_data),
        .in_last   (s_payload_last),
        .in_user   (s_payload_user),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (m_payload_data),
        .out_last  (m_payload_last),
        .out_user  (m_payload_user),
        .out_valid (m_payload_valid),
        .out_ready (m_payload_ready)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Held for 16 rising edges, released off the edge like other inputs
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

//--- test/tb_checker.sv
`timescale 1ns/1ns

module tb_checker
    import udp_echo_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              m_hdr_valid,
    input logic              m_hdr_ready,
    input logic [IP_W-1:0]   m_src_ip,
    input logic [IP_W-1:0]   m_dst_ip,
    input logic [PORT_W-1:0] m_src_port,
    input logic [PORT_W-1:0] m_dst_port,
    input logic [PORT_W-1:0] m_udp_length,
    input logic [BYTE_W-1:0] m_ttl,
    input logic [BYTE_W-1:0] m_payload_data,
    input logic              m_payload_valid,
    input logic              m_payload_ready,
    input logic              m_payload_last,
    input logic              m_payload_user
);

    // Expected replies in request order
    string             exp_name [$];
    logic [IP_W-1:0]   exp_dst_ip [$];
    logic [PORT_W-1:0] exp_dst_port [$];
    logic [PORT_W-1:0] exp_length [$];
    int                exp_count [$];
    logic [BYTE_W-1:0] exp_start [$];
    logic              exp_user [$];
    bit                exp_bad [$];

    int hdr_idx = 0;
    int pay_idx = 0;
    int byte_idx = 0;
    int done_idx = 0;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;

    task automatic add_expected(input string name, input logic [IP_W-1:0] src_ip,
                                input logic [PORT_W-1:0] src_port,
                                input logic [PORT_W-1:0] length, input int count,
                                input logic [BYTE_W-1:0] start, input logic user);
        exp_name.push_back(name);
        exp_dst_ip.push_back(src_ip);
        exp_dst_port.push_back(src_port);
        exp_length.push_back(length);
        exp_count.push_back(count);
        exp_start.push_back(start);
        exp_user.push_back(user);
        exp_bad.push_back(1'b0);
    endtask

    task automatic note_dropped(input string name);
        $display("PASS %s dropped as expected", name);
        pass_count++;
    endtask

    function automatic int open_count();
        return exp_name.size() - done_idx;
    endfunction

    task automatic compare_field(input int idx, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected %0h actual %0h", exp_name[idx], field, expected, actual);
            exp_bad[idx] = 1'b1;
            error_count++;
        end
    endtask

    task automatic check_header();
        if (hdr_idx >= exp_name.size()) begin
            $display("Unexpected reply header to port %0d with no echoed datagram pending",
                     m_dst_port);
            error_count++;
        end else begin
            compare_field(hdr_idx, "src_ip", LOCAL_IP, m_src_ip);
            compare_field(hdr_idx, "dst_ip", exp_dst_ip[hdr_idx], m_dst_ip);
            compare_field(hdr_idx, "src_port", 32'(ECHO_PORT), 32'(m_src_port));
            compare_field(hdr_idx, "dst_port", 32'(exp_dst_port[hdr_idx]), 32'(m_dst_port));
            compare_field(hdr_idx, "udp_length", 32'(exp_length[hdr_idx]), 32'(m_udp_length));
            compare_field(hdr_idx, "ttl", 32'(REPLY_TTL), 32'(m_ttl));
            hdr_idx++;
        end
    endtask

    task automatic check_byte();
        logic [BYTE_W-1:0] exp_data;
        logic              exp_last;
        if (pay_idx >= exp_name.size()) begin
            $display("Unexpected reply payload byte %0h with no echoed datagram pending",
                     m_payload_data);
            error_count++;
        end else begin
            // Request bytes count up from the start value
            exp_data = exp_start[pay_idx] + BYTE_W'(byte_idx);
            exp_last = (byte_idx == exp_count[pay_idx] - 1);
            compare_field(pay_idx, $sformatf("data[%0d]", byte_idx),
                          32'(exp_data), 32'(m_payload_data));
            compare_field(pay_idx, $sformatf("last[%0d]", byte_idx),
                          32'(exp_last), 32'(m_payload_last));
            compare_field(pay_idx, $sformatf("user[%0d]", byte_idx),
                          32'(exp_user[pay_idx]), 32'(m_payload_user));
            if (exp_last) begin
                pay_idx++;
                byte_idx = 0;
            end else begin
                byte_idx++;
            end
        end
    endtask

    // A test is over once both its header and its last byte went out
    task automatic close_finished();
        while (done_idx < hdr_idx && done_idx < pay_idx) begin
            if (exp_bad[done_idx]) begin
                $display("FAIL %s", exp_name[done_idx]);
                fail_count++;
            end else begin
                $display("PASS %s echoed %0d bytes", exp_name[done_idx], exp_count[done_idx]);
                pass_count++;
            end
            done_idx++;
        end
    endtask

    task automatic report_end(input int assert_errors);
        $display("Tests passed %0d, failed %0d, check errors %0d, assertion errors %0d",
                 pass_count, fail_count, error_count, assert_errors);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                check_header();
            end
            if (m_payload_valid && m_payload_ready) begin
                check_byte();
            end
            close_finished();
        end
    end

endmodule

//--- test/udp_echo_assertions.sv
`timescale 1ns/1ns

module udp_echo_assertions
    import udp_echo_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              m_hdr_valid,
    input logic              m_hdr_ready,
    input logic [IP_W-1:0]   m_dst_ip,
    input logic [PORT_W-1:0] m_src_port,
    input logic [PORT_W-1:0] m_dst_port,
    input logic [PORT_W-1:0] m_udp_length,
    input logic [BYTE_W-1:0] m_payload_data,
    input logic              m_payload_valid,
    input logic              m_payload_ready,
    input logic              m_payload_last,
    input logic              m_payload_user
);

    int violations = 0;

    hdr_held: assert property (
        @(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid
            && $stable({m_dst_ip, m_src_port, m_dst_port, m_udp_length})
    ) else begin
        violations++;
        $error("reply header dropped or changed before it was accepted");
    end

    payload_held: assert property (
        @(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=> m_payload_valid
            && $stable({m_payload_data, m_payload_last, m_payload_user})
    ) else begin
        violations++;
        $error("payload byte dropped or changed before it was accepted");
    end

    // Both outputs idle right after a reset edge
    reset_idle: assert property (
        @(posedge clk) rst |=> !m_hdr_valid && !m_payload_valid
    ) else begin
        violations++;
        $error("output valid high after reset");
    end

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ns

module tb_top
    import udp_echo_pkg::*;
();

    logic              clk;
    logic              rst;
    logic              s_hdr_valid;
    logic              s_hdr_ready;
    logic [IP_W-1:0]   s_src_ip;
    logic [PORT_W-1:0] s_src_port;
    logic [PORT_W-1:0] s_dst_port;
    logic [PORT_W-1:0] s_udp_length;
    logic [BYTE_W-1:0] s_payload_data;
    logic              s_payload_valid;
    logic              s_payload_ready;
    logic              s_payload_last;
    logic              s_payload_user;
    logic              m_hdr_valid;
    logic              m_hdr_ready;
    logic [IP_W-1:0]   m_src_ip;
    logic [IP_W-1:0]   m_dst_ip;
    logic [PORT_W-1:0] m_src_port;
    logic [PORT_W-1:0] m_dst_port;
    logic [PORT_W-1:0] m_udp_length;
    logic [BYTE_W-1:0] m_ttl;
    logic [BYTE_W-1:0] m_payload_data;
    logic              m_payload_valid;
    logic              m_payload_ready;
    logic              m_payload_last;
    logic              m_payload_user;

    // Trace records
    string             t_name [$];
    logic [IP_W-1:0]   t_ip [$];
    logic [PORT_W-1:0] t_sport [$];
    logic [PORT_W-1:0] t_dport [$];
    int                t_count [$];
    logic [BYTE_W-1:0] t_start [$];
    logic              t_user [$];
    logic              t_echo [$];

    integer seed = 32'he6e5_6c40;
    int     cycle_limit = 0;
    int     cycle_count = 0;
    bit     trace_ok;

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    udp_echo_top i_dut (.*);

    tb_checker i_checker (.*);

    bind udp_echo_top udp_echo_assertions i_assertions (
        .clk             (clk),
        .rst             (rst),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_dst_ip        (m_dst_ip),
        .m_src_port      (m_src_port),
        .m_dst_port      (m_dst_port),
        .m_udp_length    (m_udp_length),
        .m_payload_data  (m_payload_data),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload_last  (m_payload_last),
        .m_payload_user  (m_payload_user)
    );

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       tok;
        string       rest;
        logic [31:0] ip;
        logic [15:0] sport;
        logic [15:0] dport;
        int          count;
        logic [7:0]  start;
        int          user;
        int          echo;
        ok = 1'b0;
        fd = $fopen("test/udp_echo_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open trace file test/udp_echo_trace.txt");
            return;
        end
        ok = 1'b1;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %d %d %d %h %d %d",
                            ip, sport, dport, count, start, user, echo);
                if (n != 7 || count < 1) begin
                    $display("Trace record %s is malformed", tok);
                    ok = 1'b0;
                    break;
                end
                t_name.push_back(tok);
                t_ip.push_back(ip);
                t_sport.push_back(sport);
                t_dport.push_back(dport);
                t_count.push_back(count);
                t_start.push_back(start);
                t_user.push_back(user != 0);
                t_echo.push_back(echo != 0);
            end
        end
        $fclose(fd);
        if (t_name.size() == 0) begin
            $display("Trace file holds no datagrams");
            ok = 1'b0;
        end
    endtask

    task automatic send_datagram(input int i);
        // UDP length covers the 8-byte header plus payload
        if (t_echo[i]) begin
            i_checker.add_expected(t_name[i], t_ip[i], t_sport[i], 16'(t_count[i] + 8),
                                   t_count[i], t_start[i], t_user[i]);
        end
        s_hdr_valid  = 1'b1;
        s_src_ip     = t_ip[i];
        s_src_port   = t_sport[i];
        s_dst_port   = t_dport[i];
        s_udp_length = 16'(t_count[i] + 8);
        do @(posedge clk); while (!s_hdr_ready);
        #10;
        s_hdr_valid = 1'b0;
        for (int k = 0; k < t_count[i]; k++) begin
            s_payload_valid = 1'b1;
            s_payload_data  = t_start[i] + 8'(k);
            s_payload_last  = (k == t_count[i] - 1);
            s_payload_user  = t_user[i];
            do @(posedge clk); while (!s_payload_ready);
            #10;
        end
        s_payload_valid = 1'b0;
        s_payload_last  = 1'b0;
        if (!t_echo[i]) begin
            i_checker.note_dropped(t_name[i]);
        end
    endtask

    // Random back-pressure on both reply streams
    initial begin
        m_hdr_ready     = 1'b0;
        m_payload_ready = 1'b0;
        @(negedge rst);
        forever begin
            m_hdr_ready     = (($random(seed) & 1) != 0);
            m_payload_ready = (($random(seed) & 3) != 0);
            @(posedge clk);
            #10;
        end
    end

    initial begin : watchdog
        @(negedge rst);
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d echo replies outstanding",
                 cycle_count, i_checker.open_count());
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int total_bytes;
        s_hdr_valid     = 1'b0;
        s_src_ip        = '0;
        s_src_port      = '0;
        s_dst_port      = '0;
        s_udp_length    = '0;
        s_payload_data  = '0;
        s_payload_valid = 1'b0;
        s_payload_last  = 1'b0;
        s_payload_user  = 1'b0;
        total_bytes     = 0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Simulation failed");
            $finish;
        end else begin
            foreach (t_count[i]) begin
                total_bytes += t_count[i];
            end
            cycle_limit = 8 * total_bytes + 20 * t_name.size() + 100;
            @(negedge rst);
            for (int i = 0; i < t_name.size(); i++) begin
                send_datagram(i);
            end
            while (i_checker.open_count() != 0) begin
                @(posedge clk);
            end
            // Room for any stray output to show up
            repeat (20) @(posedge clk);
            i_checker.report_end(i_dut.i_assertions.violations);
            if (i_checker.error_count == 0 && i_dut.i_assertions.violations == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- test/udp_echo_trace.txt
# name src_ip(hex) src_port dst_port byte_count first_byte(hex) user echo
# payload bytes count up from first_byte; echo is 1 when a reply is expected
basic_echo      c0a80201 5000  1234 8  10 0 1
single_byte     c0a80202 5001  1234 1  a5 1 1
drop_port_80    c0a80203 5002  80   6  20 0 0
echo_after_drop c0a80204 5003  1234 5  30 1 1
drop_port_1235  c0a80205 5004  1235 3  40 1 0
long_echo       0a000001 40000 1234 40 00 0 1
burst_a         0a000002 1000  1234 3  f0 0 1
burst_b         0a000003 1001  1234 17 fe 1 1
burst_c         0a000004 1002  1234 2  55 0 1
drop_long       0a000005 1003  53   20 60 0 0
wrap_bytes      ac100001 65535 1234 12 f8 1 1
final_single    ac100002 7     1234 1  00 0 1

//--- flist.f
hdl/udp_echo_pkg.sv
hdl/udp_port_filter.sv
hdl/udp_reply_header.sv
hdl/payload_fifo.sv
hdl/udp_echo_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/udp_echo_assertions.sv
test/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the UDP echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_sim; then
    echo "Verilator compile failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
if ! ./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1; then
    cat sim.log
    echo "Simulator exited with an error status"
    exit 1
fi

cat sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
